// ==== rtl/node_defines.svh ====
// Node control size macros shared by the package and the RTL
`ifndef NODE_DEFINES_SVH
`define NODE_DEFINES_SVH

`default_nettype none

`define NODE_ROW_W     4   // Row address bits
`define NODE_COL_W     4   // Column address bits
`define NODE_INPUTS    8   // Inputs per node
`define NODE_OUTPUTS   8   // Outputs per node
`define NODE_STORE_LEN 32  // Mapping table entries
`define NODE_CMD_W     2   // Command field bits

// Derived index widths
`define NODE_INPUT_W  ($clog2(`NODE_INPUTS))
`define NODE_OUTPUT_W ($clog2(`NODE_OUTPUTS))
`define NODE_STORE_AW ($clog2(`NODE_STORE_LEN))

`default_nettype wire

`endif

// ==== rtl/node_pkg.sv ====
// Node package with the mapping, update, loopback, direction and message types
`include "node_defines.svh"

`default_nettype none

package node_pkg;

    // One mapping as held in the RAM
    typedef struct packed {
        logic [`NODE_ROW_W-1:0]   row;  // Target node row
        logic [`NODE_COL_W-1:0]   col;  // Target node column
        logic [`NODE_INPUT_W-1:0] idx;  // Target input index
        logic                     seq;  // Target input is sequential
    } map_entry_t;

    // Mapping write from outside
    typedef struct packed {
        logic [`NODE_OUTPUT_W-1:0] idx;  // Local output being mapped
        logic                      valid;
        map_entry_t                tgt;
    } map_req_t;

    typedef struct packed {
        logic [`NODE_INPUT_W-1:0] idx;
        logic                     seq;    // Held back until the next trigger
        logic                     state;
        logic                     valid;
    } sig_update_t;

    // Output looped back to one of our own inputs
    typedef struct packed {
        logic [`NODE_INPUT_W-1:0] idx;
        logic                     state;
        logic                     valid;
    } loopback_t;

    typedef enum logic [1:0] {
        DIR_NORTH,
        DIR_EAST,
        DIR_SOUTH,
        DIR_WEST
    } direction_t;

    // Outbound signal state message
    typedef struct packed {
        logic [`NODE_ROW_W-1:0]   row;
        logic [`NODE_COL_W-1:0]   col;
        logic [`NODE_CMD_W-1:0]   cmd;
        logic [`NODE_INPUT_W-1:0] idx;
        logic                     seq;
        logic                     state;
    } msg_t;

    localparam logic [`NODE_CMD_W-1:0] CMD_SIG_STATE = 2'd1;

endpackage : node_pkg

`default_nettype wire

// ==== rtl/node_fifo.sv ====
// Small first-word-fall-through FIFO carrying any payload type
`timescale 1ns/1ps
`default_nettype none

module node_fifo #(
      parameter int  DEPTH    = 3
    , parameter int  FULL_LVL = DEPTH  // Occupancy that reports full
    , parameter type T        = logic
) (
      input  logic clk_i
    , input  logic reset_i
    , input  T     wr_data_i
    , input  logic wr_push_i
    , output T     rd_data_o   // Head word, valid while not empty
    , input  logic rd_pop_i
    , output logic empty_o
    , output logic full_o
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    // Circular pointer step
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign do_push   = wr_push_i && (count_q != CNT_W'(DEPTH));  // Drop on overflow
    assign do_pop    = rd_pop_i && !empty_o;
    assign empty_o   = count_q == '0;
    assign full_o    = count_q >= CNT_W'(FULL_LVL);
    assign rd_data_o = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) wr_ptr_q <= ptr_inc(wr_ptr_q);
            if (do_pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;  // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= wr_data_i;
        end
    end

endmodule : node_fifo

`default_nettype wire

// ==== rtl/map_store.sv ====
// Mapping RAM holding target entries, written and read in one edge each
`include "node_defines.svh"

`timescale 1ns/1ps
`default_nettype none

module map_store
    import node_pkg::*;
(
      input  logic                      clk_i
    , input  logic [`NODE_STORE_AW-1:0] addr_i
    , input  logic                      wr_en_i
    , input  map_entry_t                wr_data_i
    , input  logic                      rd_en_i
    , output map_entry_t                rd_data_o  // Valid the cycle after rd_en_i
);

    map_entry_t mem_q [`NODE_STORE_LEN];

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem_q[addr_i] <= wr_data_i;
        end
        if (rd_en_i) begin
            rd_data_o <= mem_q[addr_i];  // Held until the next read
        end
    end

endmodule : map_store

`default_nettype wire

// ==== rtl/output_scanner.sv ====
// Output scanner that records mappings and walks the ranges of changed core outputs
`include "node_defines.svh"

`timescale 1ns/1ps
`default_nettype none

module output_scanner
    import node_pkg::*;
(
      input  logic                      clk_i
    , input  logic                      reset_i
    , input  map_req_t                  map_i
    , input  logic [`NODE_OUTPUTS-1:0]  core_outputs_i
    , input  logic                      fifo_full_i     // State FIFO at its stall level
    , output logic [`NODE_STORE_AW-1:0] store_addr_o
    , output logic                      store_wr_en_o
    , output map_entry_t                store_wr_data_o
    , output logic                      store_rd_en_o
    , output logic                      state_push_o
    , output logic                      state_bit_o
    , output logic                      entry_push_o
);

    localparam int AW = `NODE_STORE_AW;
    localparam int OW = `NODE_OUTPUT_W;

    // Per output mapping ranges
    logic [AW-1:0]            base_q [`NODE_OUTPUTS];
    logic [AW:0]              num_q  [`NODE_OUTPUTS];  // Extra bit so a full table fits
    logic [AW-1:0]            next_free_q;
    logic [`NODE_OUTPUTS-1:0] last_q;
    logic [`NODE_OUTPUTS-1:0] last_d;

    // Detection stage
    logic          found;
    logic [OW-1:0] found_idx;
    logic          upd_req_q;
    logic [OW-1:0] upd_idx_q;
    logic [AW-1:0] upd_base;
    logic [AW-1:0] upd_final;
    logic          new_bit;

    // Range walk
    logic          active_q;
    logic [AW-1:0] rd_addr_q;   // Next address to read
    logic [AW-1:0] rd_last_q;
    logic          send_val_q;  // State sent for the whole range
    logic          rd_pend_q;
    logic          read_ok;
    logic          start;
    logic          step;

    assign upd_base  = base_q[upd_idx_q];
    assign upd_final = upd_base + num_q[upd_idx_q][AW-1:0] - 1'b1;
    assign new_bit   = core_outputs_i[upd_idx_q];

    assign read_ok = !map_i.valid && !fifo_full_i;  // Writes win over reads
    assign step    = read_ok && active_q;
    assign start   = read_ok && !active_q && upd_req_q;

    assign store_wr_en_o   = map_i.valid;
    assign store_wr_data_o = map_i.tgt;
    assign store_rd_en_o   = step || start;
    assign store_addr_o    = map_i.valid ? next_free_q : (active_q ? rd_addr_q : upd_base);

    assign state_push_o = store_rd_en_o;                     // State goes in with the read
    assign state_bit_o  = active_q ? send_val_q : new_bit;
    assign entry_push_o = rd_pend_q;                         // RAM answer one cycle later

    // Last sent values as they stand after this edge
    always_comb begin
        last_d = last_q;
        if (start) begin
            last_d[upd_idx_q] = new_bit;
        end
    end

    // Lowest changed output with at least one mapping
    always_comb begin
        found     = 1'b0;
        found_idx = '0;
        for (int i = 0; i < `NODE_OUTPUTS; i++) begin
            if (!found && core_outputs_i[i] != last_d[i] && num_q[i] != '0) begin
                found     = 1'b1;
                found_idx = OW'(i);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < `NODE_OUTPUTS; i++) begin
                num_q[i] <= '0;
            end
            next_free_q <= '0;
            last_q      <= '0;
            upd_req_q   <= 1'b0;
            active_q    <= 1'b0;
            rd_pend_q   <= 1'b0;
        end else begin
            last_q    <= last_d;
            upd_req_q <= found;
            rd_pend_q <= store_rd_en_o;
            if (map_i.valid) begin
                num_q[map_i.idx] <= num_q[map_i.idx] + 1'b1;
                next_free_q      <= next_free_q + 1'b1;  // Table never wraps
            end
            if (step) begin
                active_q <= rd_addr_q != rd_last_q;
            end else if (start) begin
                active_q <= upd_base != upd_final;  // Single entry range is done at once
            end
        end
    end

    always_ff @(posedge clk_i) begin
        upd_idx_q <= found_idx;
        if (map_i.valid && num_q[map_i.idx] == '0) begin
            base_q[map_i.idx] <= next_free_q;  // First mapping opens the range
        end
        if (step) begin
            rd_addr_q <= rd_addr_q + 1'b1;
        end else if (start) begin
            rd_addr_q  <= upd_base + 1'b1;
            rd_last_q  <= upd_final;
            send_val_q <= new_bit;
        end
    end

endmodule : output_scanner

`default_nettype wire

// ==== rtl/msg_emitter.sv ====
// Message emitter that holds the channel token, routes messages and issues loopbacks
`include "node_defines.svh"

`timescale 1ns/1ps
`default_nettype none

module msg_emitter
    import node_pkg::*;
(
      input  logic                   clk_i
    , input  logic                   reset_i
    , input  logic [`NODE_ROW_W-1:0] node_row_i
    , input  logic [`NODE_COL_W-1:0] node_col_i
    , input  map_entry_t             entry_i          // Head of the entry FIFO
    , input  logic                   state_i          // Head of the state FIFO
    , input  logic                   fifos_empty_i    // Nothing to pop yet
    , output logic                   pop_o            // Pops both FIFOs
    , input  logic                   token_grant_i
    , output logic                   token_release_o
    , output msg_t                   msg_data_o
    , output direction_t             msg_dir_o
    , output logic                   msg_valid_o
    , input  logic                   msg_ready_i
    , output loopback_t              loopback_o
    , output logic                   idle_o
);

    logic       is_local;
    logic       lb_fire;
    logic       send_fire;
    logic       no_work;
    logic       token_held_q;
    logic       token_release_q;
    logic       msg_valid_q;
    msg_t       msg_data_q;
    direction_t msg_dir_q;
    direction_t route;
    loopback_t  loopback_q;

    assign is_local = entry_i.row == node_row_i && entry_i.col == node_col_i;
    assign lb_fire  = !fifos_empty_i && is_local;  // Loopbacks need no token
    // New message only into an empty or draining slot
    assign send_fire = !fifos_empty_i && !is_local && token_held_q
                    && (!msg_valid_q || msg_ready_i);
    assign pop_o   = lb_fire || send_fire;
    assign no_work = fifos_empty_i && !msg_valid_q;

    // Rows first, then columns
    always_comb begin
        if (entry_i.row < node_row_i) route = DIR_NORTH;
        else if (entry_i.row > node_row_i) route = DIR_SOUTH;
        else if (entry_i.col < node_col_i) route = DIR_WEST;
        else route = DIR_EAST;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            token_held_q    <= 1'b0;
            token_release_q <= 1'b0;
            msg_valid_q     <= 1'b0;
            loopback_q      <= '0;
        end else begin
            token_release_q <= 1'b0;  // One cycle pulse
            if (token_held_q && no_work) begin
                token_held_q    <= 1'b0;
                token_release_q <= 1'b1;
            end else if (!token_held_q && token_grant_i) begin
                token_held_q    <= !no_work;
                token_release_q <= no_work;  // Hand straight back when idle
            end
            if (send_fire) msg_valid_q <= 1'b1;
            else if (msg_ready_i) msg_valid_q <= 1'b0;
            loopback_q.idx   <= entry_i.idx;
            loopback_q.state <= state_i;
            loopback_q.valid <= lb_fire;
        end
    end

    always_ff @(posedge clk_i) begin
        if (send_fire) begin
            msg_data_q.row   <= entry_i.row;
            msg_data_q.col   <= entry_i.col;
            msg_data_q.cmd   <= CMD_SIG_STATE;
            msg_data_q.idx   <= entry_i.idx;
            msg_data_q.seq   <= entry_i.seq;
            msg_data_q.state <= state_i;
            msg_dir_q        <= route;
        end
    end

    assign msg_data_o      = msg_data_q;
    assign msg_dir_o       = msg_dir_q;
    assign msg_valid_o     = msg_valid_q;
    assign token_release_o = token_release_q;
    assign loopback_o      = loopback_q;
    assign idle_o          = no_work && !loopback_q.valid;

endmodule : msg_emitter

`default_nettype wire

// ==== rtl/input_tracker.sv ====
// Input tracker keeping current and next input state and raising the core trigger
`include "node_defines.svh"

`timescale 1ns/1ps
`default_nettype none

module input_tracker
    import node_pkg::*;
(
      input  logic                    clk_i
    , input  logic                    reset_i
    , input  logic                    trigger_i
    , input  sig_update_t             update_i
    , input  loopback_t               loopback_i
    , output logic                    core_trigger_o
    , output logic [`NODE_INPUTS-1:0] core_inputs_o
);

    logic [`NODE_INPUTS-1:0] cur_q;
    logic [`NODE_INPUTS-1:0] cur_d;
    logic [`NODE_INPUTS-1:0] nxt_q;   // Staged until the next trigger
    logic [`NODE_INPUTS-1:0] nxt_d;
    logic                    first_q;
    logic                    first_d;
    logic                    trig_q;
    logic                    trig_d;

    always_comb begin
        cur_d   = cur_q;
        nxt_d   = nxt_q;
        first_d = first_q;
        trig_d  = 1'b0;
        if (trigger_i) begin
            trig_d  = (cur_q != nxt_q) || first_q;  // First trigger always fires
            cur_d   = nxt_q;
            first_d = 1'b0;
        end
        if (update_i.valid) begin
            nxt_d[update_i.idx] = update_i.state;
            if (!update_i.seq) begin
                cur_d[update_i.idx] = update_i.state;  // Combinational input, live now
                if (cur_q[update_i.idx] != update_i.state) trig_d = 1'b1;
            end
        end
        // Loopbacks are always sequential
        if (loopback_i.valid) nxt_d[loopback_i.idx] = loopback_i.state;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cur_q   <= '0;
            nxt_q   <= '0;
            first_q <= 1'b1;
            trig_q  <= 1'b0;
        end else begin
            cur_q   <= cur_d;
            nxt_q   <= nxt_d;
            first_q <= first_d;
            trig_q  <= trig_d;
        end
    end

    assign core_trigger_o = trig_q;
    assign core_inputs_o  = cur_q;

endmodule : input_tracker

`default_nettype wire

// ==== rtl/node_control_top.sv ====
// Node control top joining scanner, mapping RAM, FIFOs, emitter and input tracker
`include "node_defines.svh"

`timescale 1ns/1ps
`default_nettype none

module node_control_top
    import node_pkg::*;
(
      input  logic                     clk_i
    , input  logic                     reset_i
    , input  map_req_t                 map_i
    , input  sig_update_t              update_i
    , input  logic                     trigger_i
    , input  logic                     token_grant_i
    , input  logic                     msg_ready_i
    , input  logic [`NODE_ROW_W-1:0]   node_row_i
    , input  logic [`NODE_COL_W-1:0]   node_col_i
    , input  logic [`NODE_OUTPUTS-1:0] core_outputs_i
    , output msg_t                     msg_data_o
    , output direction_t               msg_dir_o
    , output logic                     msg_valid_o
    , output logic                     token_release_o
    , output logic                     core_trigger_o
    , output logic [`NODE_INPUTS-1:0]  core_inputs_o
    , output logic                     idle_o
);

    logic [`NODE_STORE_AW-1:0] store_addr;
    logic                      store_wr_en;
    logic                      store_rd_en;
    map_entry_t                store_wr_data;
    map_entry_t                store_rd_data;
    logic                      state_push;
    logic                      state_bit;
    logic                      state_head;
    logic                      state_empty;
    logic                      state_full;
    logic                      entry_push;
    map_entry_t                entry_head;
    logic                      entry_empty;
    logic                      fifo_pop;
    loopback_t                 loopback;

    output_scanner u_scanner (
          .clk_i          (clk_i)
        , .reset_i        (reset_i)
        , .map_i          (map_i)
        , .core_outputs_i (core_outputs_i)
        , .fifo_full_i    (state_full)
        , .store_addr_o   (store_addr)
        , .store_wr_en_o  (store_wr_en)
        , .store_wr_data_o(store_wr_data)
        , .store_rd_en_o  (store_rd_en)
        , .state_push_o   (state_push)
        , .state_bit_o    (state_bit)
        , .entry_push_o   (entry_push)
    );

    map_store u_store (
          .clk_i    (clk_i)
        , .addr_i   (store_addr)
        , .wr_en_i  (store_wr_en)
        , .wr_data_i(store_wr_data)
        , .rd_en_i  (store_rd_en)
        , .rd_data_o(store_rd_data)
    );

    // Stall level leaves room for the read still in flight
    node_fifo #(.DEPTH(3), .FULL_LVL(2), .T(logic)) u_state_fifo (
          .clk_i    (clk_i)
        , .reset_i  (reset_i)
        , .wr_data_i(state_bit)
        , .wr_push_i(state_push)
        , .rd_data_o(state_head)
        , .rd_pop_i (fifo_pop)
        , .empty_o  (state_empty)
        , .full_o   (state_full)
    );

    node_fifo #(.DEPTH(3), .T(map_entry_t)) u_entry_fifo (
          .clk_i    (clk_i)
        , .reset_i  (reset_i)
        , .wr_data_i(store_rd_data)
        , .wr_push_i(entry_push)
        , .rd_data_o(entry_head)
        , .rd_pop_i (fifo_pop)
        , .empty_o  (entry_empty)
        , .full_o   ()               // Throttled through the state FIFO
    );

    msg_emitter u_emitter (
          .clk_i          (clk_i)
        , .reset_i        (reset_i)
        , .node_row_i     (node_row_i)
        , .node_col_i     (node_col_i)
        , .entry_i        (entry_head)
        , .state_i        (state_head)
        , .fifos_empty_i  (state_empty || entry_empty)  // Entry trails state by a cycle
        , .pop_o          (fifo_pop)
        , .token_grant_i  (token_grant_i)
        , .token_release_o(token_release_o)
        , .msg_data_o     (msg_data_o)
        , .msg_dir_o      (msg_dir_o)
        , .msg_valid_o    (msg_valid_o)
        , .msg_ready_i    (msg_ready_i)
        , .loopback_o     (loopback)
        , .idle_o         (idle_o)
    );

    input_tracker u_tracker (
          .clk_i         (clk_i)
        , .reset_i       (reset_i)
        , .trigger_i     (trigger_i)
        , .update_i      (update_i)
        , .loopback_i    (loopback)
        , .core_trigger_o(core_trigger_o)
        , .core_inputs_o (core_inputs_o)
    );

endmodule : node_control_top

`default_nettype wire

// ==== verification/node_control_tb.sv ====
// Node control testbench with reference model and concurrent checks on messages, token and inputs
`include "node_defines.svh"

`timescale 1ns/1ps
`default_nettype none

module node_control_tb
    import node_pkg::*;
();

    localparam logic [`NODE_ROW_W-1:0] MY_ROW = 4'd5;
    localparam logic [`NODE_COL_W-1:0] MY_COL = 4'd6;
    localparam int TIMEOUT_CYCLES = 4000;  // Full run takes a few hundred cycles

    logic                     clk_i = 1'b0;
    logic                     reset_i = 1'b1;
    map_req_t                 map_i;
    sig_update_t              update_i;
    logic                     trigger_i;
    logic                     token_grant_i;
    logic                     msg_ready_i;
    logic [`NODE_ROW_W-1:0]   node_row_i;
    logic [`NODE_COL_W-1:0]   node_col_i;
    logic [`NODE_OUTPUTS-1:0] core_outputs_i;
    msg_t                     msg_data_o;
    direction_t               msg_dir_o;
    logic                     msg_valid_o;
    logic                     token_release_o;
    logic                     core_trigger_o;
    logic [`NODE_INPUTS-1:0]  core_inputs_o;
    logic                     idle_o;

    // Reference model state
    map_entry_t              map_tab [`NODE_OUTPUTS][8];  // Mappings per output, in order
    int                      map_cnt [`NODE_OUTPUTS];
    msg_t                    exp_msg_arr [128];           // Expected messages, oldest first
    direction_t              exp_dir_arr [128];
    int                      exp_wr = 0;
    int                      exp_rd = 0;                  // Advances on each transfer
    msg_t                    exp_msg;
    direction_t              exp_dir;
    logic [`NODE_INPUT_W-1:0] lb_idx [8];                 // Loopbacks still to reach next state
    logic                    lb_val [8];
    int                      lb_cnt = 0;
    logic [`NODE_INPUTS-1:0] mdl_cur = '0;                // Tracker state after the coming edge
    logic [`NODE_INPUTS-1:0] mdl_nxt = '0;
    logic                    mdl_first = 1'b1;
    logic                    mdl_fire = 1'b0;
    logic [`NODE_INPUTS-1:0] exp_inputs = '0;             // What the DUT shows this cycle
    logic                    exp_trig = 1'b0;
    logic                    holder;                      // Token with the node
    logic                    random_ready = 1'b0;
    logic [31:0]             rng = 32'd96;
    string                   test_name = "reset";
    int                      cycle_cnt = 0;

    node_control_top u_node_control_top (
          .clk_i          (clk_i)
        , .reset_i        (reset_i)
        , .map_i          (map_i)
        , .update_i       (update_i)
        , .trigger_i      (trigger_i)
        , .token_grant_i  (token_grant_i)
        , .msg_ready_i    (msg_ready_i)
        , .node_row_i     (node_row_i)
        , .node_col_i     (node_col_i)
        , .core_outputs_i (core_outputs_i)
        , .msg_data_o     (msg_data_o)
        , .msg_dir_o      (msg_dir_o)
        , .msg_valid_o    (msg_valid_o)
        , .token_release_o(token_release_o)
        , .core_trigger_o (core_trigger_o)
        , .core_inputs_o  (core_inputs_o)
        , .idle_o         (idle_o)
    );

    always #4 clk_i = ~clk_i;  // 8 ns period

    assign exp_msg = exp_msg_arr[exp_rd];
    assign exp_dir = exp_dir_arr[exp_rd];

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "Run stopped at first error");
    endtask

    // Run guard
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            report_failure($sformatf("Timeout in test %s after %0d cycles", test_name, cycle_cnt));
        end
    end

    always @(posedge clk_i) begin
        if (reset_i) begin
            exp_rd <= 0;
            holder <= 1'b0;
        end else begin
            if (msg_valid_o && msg_ready_i) exp_rd <= exp_rd + 1;  // One transfer per edge
            if (token_grant_i) holder <= 1'b1;
            else if (token_release_o) holder <= 1'b0;
        end
    end

    // Stream content against the expected queue
    a_no_extra: assert property (@(posedge clk_i) disable iff (reset_i)
        (msg_valid_o && msg_ready_i) |-> (exp_rd < exp_wr))
        else report_failure($sformatf("Test %s sent a message that no mapping asked for", test_name));
    a_msg_data: assert property (@(posedge clk_i) disable iff (reset_i)
        (msg_valid_o && msg_ready_i) |-> (msg_data_o == exp_msg))
        else report_failure($sformatf("MISMATCH test %s message expected %h actual %h",
            test_name, $sampled(exp_msg), $sampled(msg_data_o)));
    a_msg_dir: assert property (@(posedge clk_i) disable iff (reset_i)
        (msg_valid_o && msg_ready_i) |-> (msg_dir_o == exp_dir))
        else report_failure($sformatf("MISMATCH test %s direction expected %0d actual %0d",
            test_name, $sampled(exp_dir), $sampled(msg_dir_o)));
    a_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        (msg_valid_o && !msg_ready_i) |=> (msg_valid_o && $stable(msg_data_o) && $stable(msg_dir_o)))
        else report_failure($sformatf("Test %s changed a message before it was taken", test_name));

    // Token ownership
    a_token_needed: assert property (@(posedge clk_i) disable iff (reset_i)
        msg_valid_o |-> holder)
        else report_failure($sformatf("Test %s sent a message without the token", test_name));
    a_release_single: assert property (@(posedge clk_i) disable iff (reset_i)
        token_release_o |=> !token_release_o)
        else report_failure($sformatf("Test %s released the token twice in a row", test_name));
    a_release_done: assert property (@(posedge clk_i) disable iff (reset_i)
        token_release_o |-> (exp_rd == exp_wr && holder))
        else report_failure($sformatf("Test %s released the token with work left", test_name));
    a_quick_release: assert property (@(posedge clk_i) disable iff (reset_i)
        (token_grant_i && idle_o) |=> token_release_o)
        else report_failure($sformatf("Test %s kept a token it had no use for", test_name));

    // Input tracker against the model
    a_inputs: assert property (@(posedge clk_i) disable iff (reset_i)
        core_inputs_o == exp_inputs)
        else report_failure($sformatf("MISMATCH test %s core_inputs expected %b actual %b",
            test_name, $sampled(exp_inputs), $sampled(core_inputs_o)));
    a_trigger: assert property (@(posedge clk_i) disable iff (reset_i)
        core_trigger_o == exp_trig)
        else report_failure($sformatf("MISMATCH test %s core_trigger expected %b actual %b",
            test_name, $sampled(exp_trig), $sampled(core_trigger_o)));
    a_reset_state: assert property (@(posedge clk_i)
        $fell(reset_i) |-> (!msg_valid_o && !token_release_o && !core_trigger_o && idle_o))
        else report_failure("Outputs not at their reset values after reset");

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Row decides first, column only on the same row
    function automatic direction_t expected_dir(input map_entry_t e);
        if (e.row != MY_ROW) return (e.row < MY_ROW) ? DIR_NORTH : DIR_SOUTH;
        return (e.col < MY_COL) ? DIR_WEST : DIR_EAST;
    endfunction

    // One clock, inputs change 1 ns after the edge
    task automatic step();
        @(posedge clk_i);
        #1;
        exp_inputs    = mdl_cur;
        exp_trig      = mdl_fire;
        mdl_fire      = 1'b0;
        trigger_i     = 1'b0;  // Strobes last one cycle
        token_grant_i = 1'b0;
        map_i.valid   = 1'b0;
        update_i.valid = 1'b0;
        if (random_ready) begin
            rng         = xorshift32(rng);
            msg_ready_i = rng[1:0] != 2'b00;  // Ready about three cycles in four
        end else begin
            msg_ready_i = 1'b1;
        end
    endtask

    task automatic pick_target(output map_entry_t e);
        rng = xorshift32(rng);
        e   = map_entry_t'(rng[$bits(map_entry_t)-1:0]);
        if (e.row == MY_ROW && e.col == MY_COL) e.col = e.col + 1'b1;  // Keep it remote
    endtask

    task automatic write_map(input int o, input map_entry_t e);
        map_i.idx   = o[`NODE_OUTPUT_W-1:0];
        map_i.tgt   = e;
        map_i.valid = 1'b1;
        map_tab[o][map_cnt[o]] = e;
        map_cnt[o]++;
        step();
    endtask

    task automatic pulse_trigger();
        trigger_i = 1'b1;
        mdl_fire  = (mdl_cur != mdl_nxt) || mdl_first;
        mdl_cur   = mdl_nxt;
        mdl_first = 1'b0;
        step();
    endtask

    task automatic send_update(input int idx, input logic seq, input logic state);
        update_i.idx   = idx[`NODE_INPUT_W-1:0];
        update_i.seq   = seq;
        update_i.state = state;
        update_i.valid = 1'b1;
        mdl_nxt[idx]   = state;
        if (!seq) begin
            if (mdl_cur[idx] != state) mdl_fire = 1'b1;
            mdl_cur[idx] = state;  // Live at once
        end
        step();
    endtask

    // Flip one core output and queue what its mappings must produce
    task automatic toggle_output(input int o);
        logic       val;
        map_entry_t e;
        msg_t       m;
        core_outputs_i[o] = ~core_outputs_i[o];
        val = core_outputs_i[o];
        for (int k = 0; k < map_cnt[o]; k++) begin
            e = map_tab[o][k];
            if (e.row == MY_ROW && e.col == MY_COL) begin
                lb_idx[lb_cnt] = e.idx;
                lb_val[lb_cnt] = val;
                lb_cnt++;
            end else begin
                m.row   = e.row;
                m.col   = e.col;
                m.cmd   = CMD_SIG_STATE;
                m.idx   = e.idx;
                m.seq   = e.seq;
                m.state = val;
                exp_msg_arr[exp_wr] = m;
                exp_dir_arr[exp_wr] = expected_dir(e);
                exp_wr++;
            end
        end
        step();
    endtask

    task automatic wait_busy();
        while (idle_o) step();
    endtask

    task automatic wait_idle();
        while (!idle_o) step();
    endtask

    task automatic apply_loopbacks();
        for (int i = 0; i < lb_cnt; i++) begin
            mdl_nxt[lb_idx[i]] = lb_val[i];
        end
        lb_cnt = 0;
    endtask

    // Hold back the token a while, then grant and let everything drain
    task automatic grant_and_drain();
        wait_busy();
        repeat (10) step();
        token_grant_i = 1'b1;
        step();
        while (holder || exp_rd != exp_wr) step();
        wait_idle();
    endtask

    initial begin
        map_entry_t e;
        int         sel;
        map_i          = '0;
        update_i       = '0;
        trigger_i      = 1'b0;
        token_grant_i  = 1'b0;
        msg_ready_i    = 1'b1;
        node_row_i     = MY_ROW;
        node_col_i     = MY_COL;
        core_outputs_i = '0;
        for (int o = 0; o < `NODE_OUTPUTS; o++) map_cnt[o] = 0;
        repeat (5) @(posedge clk_i);
        #1;
        reset_i = 1'b0;

        test_name = "first_trigger";
        pulse_trigger();  // Fires with nothing changed
        step();
        pulse_trigger();
        step();

        test_name = "updates";
        send_update(2, 1'b0, 1'b1);
        step();
        send_update(2, 1'b0, 1'b1);  // Same value again
        step();
        send_update(3, 1'b1, 1'b1);  // Held until the trigger
        step();
        pulse_trigger();
        send_update(3, 1'b1, 1'b0);
        pulse_trigger();
        step();

        // Mappings of one output must be written back to back
        test_name = "mappings";
        for (int k = 0; k < 3; k++) begin
            pick_target(e);
            write_map(0, e);
        end
        e     = '0;
        e.row = MY_ROW;
        e.col = MY_COL;
        e.idx = 3'd5;
        e.seq = 1'b1;
        write_map(1, e);  // Own address, looped back
        for (int k = 0; k < 2; k++) begin
            pick_target(e);
            write_map(2, e);
        end
        for (int k = 0; k < 4; k++) begin
            pick_target(e);
            write_map(4, e);
        end

        test_name = "route";
        toggle_output(0);
        grant_and_drain();

        test_name = "unmapped";
        toggle_output(3);
        repeat (12) step();
        assert (idle_o) else report_failure("idle_o went low for an output with no mappings");

        test_name = "idle_grant";
        token_grant_i = 1'b1;
        step();
        repeat (3) step();

        test_name    = "backpressure";
        random_ready = 1'b1;
        repeat (6) begin
            rng = xorshift32(rng);
            sel = int'(rng % 32'd3);
            toggle_output(sel * 2);  // Outputs 0, 2 and 4
            grant_and_drain();
        end
        random_ready = 1'b0;
        step();

        // Token granted so a wrongly routed loopback would show on the stream
        test_name = "loopback";
        repeat (2) begin
            toggle_output(1);
            grant_and_drain();
            apply_loopbacks();
            pulse_trigger();
            step();
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule : node_control_tb

`default_nettype wire

// ==== src.f ====
+incdir+rtl
rtl/node_pkg.sv
rtl/node_fifo.sv
rtl/map_store.sv
rtl/output_scanner.sv
rtl/msg_emitter.sv
rtl/input_tracker.sv
rtl/node_control_top.sv
verification/node_control_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the node control testbench with Verilator and run it
# A $fatal in the testbench gives a non-zero exit status, which set -e passes on
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f src.f \
    --top-module node_control_tb \
    -o node_control_sim

./obj_dir/node_control_sim
